// ==== rtl/cpu_map_pkg.sv ====
`default_nettype none

package cpu_map_pkg;

    // what an access hits, decided from the full 16-bit address
    typedef enum logic [2:0] {
        REGION_RAM,
        REGION_PPU,
        REGION_OAMDMA,
        REGION_JOYPAD,
        REGION_OPEN
    } bus_region_t;

    // 2 KB of work RAM, mirrored four times below PPU_BASE
    localparam int RAM_WORDS = 2048;

    // region boundaries
    localparam logic [15:0] PPU_BASE = 16'h2000;
    localparam logic [15:0] IO_BASE  = 16'h4000;

    // single-address registers in the io page
    localparam logic [15:0] OAMDMA_ADDR = 16'h4014;
    localparam logic [15:0] JOYPAD_ADDR = 16'h4016;

    // dma destination, PPU register 4
    localparam logic [15:0] OAMDATA_ADDR = 16'h2004;

endpackage : cpu_map_pkg

`default_nettype wire

// ==== rtl/io_pkg.sv ====
`default_nettype none

package io_pkg;

    // PPU registers, picked by address bits 2:0
    typedef enum logic [2:0] {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        OAMADDR   = 3'd3,
        OAMDATA   = 3'd4,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } ppu_reg_t;

    // controller port states
    typedef enum logic [1:0] {
        JOY_IDLE,
        JOY_STROBE,
        JOY_SHIFT
    } joy_state_t;

    // buttons vector index order: A, B, Select, Start, Up, Down, Left, Right
    localparam int BUTTON_COUNT = 8;

endpackage : io_pkg

`default_nettype wire

// ==== rtl/cpu_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one access per cycle, no valid
// r_data answers the access of the previous cycle
interface cpu_bus_if;

    logic [15:0] addr;
    // high reads, low writes
    logic        r_en;
    logic [7:0]  w_data;
    logic [7:0]  r_data;

    modport master (
        output addr,
        output r_en,
        output w_data,
        input  r_data
    );

    modport slave (
        input  addr,
        input  r_en,
        input  w_data,
        output r_data
    );

endinterface : cpu_bus_if

`default_nettype wire

// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire        clock,
    input  wire        reset_n,
    cpu_bus_if.slave   host,
    cpu_bus_if.slave   dma,
    cpu_bus_if.master  mem,
    input  wire        busy,
    output logic       cpu_ready
);

    // owner of the access that r_data answers this cycle
    logic grant_q;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            grant_q <= 1'b0;
        end else begin
            grant_q <= busy;
        end
    end

    // dma owns the bus for as long as busy is up
    always_comb begin
        if (busy) begin
            mem.addr   = dma.addr;
            mem.r_en   = dma.r_en;
            mem.w_data = dma.w_data;
        end else begin
            mem.addr   = host.addr;
            mem.r_en   = host.r_en;
            mem.w_data = host.w_data;
        end
    end

    assign host.r_data = mem.r_data;

    // engine only sees data that answers its own reads
    assign dma.r_data = grant_q ? mem.r_data : 8'h00;

    assign cpu_ready = ~busy;

    // first dma cycle is always the read of byte 0
    a_grant_opens_with_read : assert property (
        @(posedge clock) disable iff (!reset_n)
        busy && !grant_q |-> mem.r_en
    );

    // read and write alternate with no gap while the grant holds
    a_grant_alternates : assert property (
        @(posedge clock) disable iff (!reset_n)
        grant_q && busy |-> mem.r_en != $past(mem.r_en)
    );

endmodule : bus_arbiter

`default_nettype wire

// ==== rtl/oam_dma.sv ====
`timescale 1ns/1ps
`default_nettype none

module oam_dma #(
    parameter int DMA_BYTES = 256
) (
    input  wire        clock,
    input  wire        reset_n,
    input  wire        dma_start,
    input  wire  [7:0] dma_page,
    output logic       busy,
    cpu_bus_if.master  bus
);

    import cpu_map_pkg::*;

    localparam logic [7:0] LAST_IDX = 8'(DMA_BYTES - 1);

    logic [7:0] page_q;
    logic [7:0] idx_q;
    // low reads the source byte, high writes it to OAMDATA
    logic       write_phase;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy        <= 1'b0;
            write_phase <= 1'b0;
            idx_q       <= 8'h00;
        end else if (dma_start) begin
            busy        <= 1'b1;
            write_phase <= 1'b0;
            idx_q       <= 8'h00;
        end else if (busy) begin
            write_phase <= ~write_phase;
            if (write_phase) begin
                idx_q <= idx_q + 8'h01;
                // last write done, hand the bus back
                if (idx_q == LAST_IDX) begin
                    busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (dma_start) begin
            page_q <= dma_page;
        end
    end

    assign bus.addr   = write_phase ? OAMDATA_ADDR : {page_q, idx_q};
    assign bus.r_en   = ~write_phase;
    // byte read in the cycle before
    assign bus.w_data = bus.r_data;

    // host is stalled during a copy, so no new trigger can reach the decoder
    a_no_start_while_busy : assert property (
        @(posedge clock) disable iff (!reset_n)
        dma_start |-> !busy
    );

endmodule : oam_dma

`default_nettype wire

// ==== rtl/bus_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module bus_decoder #(
    parameter int RAM_WORDS = cpu_map_pkg::RAM_WORDS
) (
    input  wire              clock,
    input  wire              reset_n,
    cpu_bus_if.slave         bus,
    output logic             reg_en,
    output io_pkg::ppu_reg_t reg_sel,
    output logic             reg_rw,
    output logic [7:0]       reg_data_wr,
    input  wire  [7:0]       reg_data_rd,
    output logic             dma_start,
    output logic [7:0]       dma_page,
    output logic             joy_write,
    output logic             joy_strobe_bit,
    output logic             joy_read,
    input  wire              joy_bit
);

    import cpu_map_pkg::*;
    import io_pkg::*;

    localparam int RAM_AW = $clog2(RAM_WORDS);

    bus_region_t       region;
    // region of the last read, writes leave the data bus alone
    bus_region_t       prev_sel;
    logic [7:0]        ram [RAM_WORDS];
    logic [RAM_AW-1:0] ram_idx;
    logic [7:0]        ram_q;
    logic              joy_q;
    logic [7:0]        open_q;

    always_comb begin
        if (bus.addr < PPU_BASE) begin
            region = REGION_RAM;
        end else if (bus.addr < IO_BASE) begin
            region = REGION_PPU;
        end else if (bus.addr == OAMDMA_ADDR) begin
            region = REGION_OAMDMA;
        end else if (bus.addr == JOYPAD_ADDR) begin
            region = REGION_JOYPAD;
        end else begin
            region = REGION_OPEN;
        end
    end

    // mirroring falls out of dropping the upper bits
    assign ram_idx = bus.addr[RAM_AW-1:0];

    always_ff @(posedge clock) begin
        if (region == REGION_RAM) begin
            if (bus.r_en) begin
                ram_q <= ram[ram_idx];
            end else begin
                ram[ram_idx] <= bus.w_data;
            end
        end
    end

    // PPU register port
    assign reg_en      = (region == REGION_PPU);
    assign reg_sel     = ppu_reg_t'(bus.addr[2:0]);
    assign reg_rw      = ~bus.r_en;
    assign reg_data_wr = bus.w_data;

    assign dma_start = (region == REGION_OAMDMA) && !bus.r_en;
    assign dma_page  = bus.w_data;

    assign joy_write      = (region == REGION_JOYPAD) && !bus.r_en;
    assign joy_strobe_bit = bus.w_data[0];
    assign joy_read       = (region == REGION_JOYPAD) && bus.r_en;

    always_ff @(posedge clock) begin
        if (joy_read) begin
            joy_q <= joy_bit;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            prev_sel <= REGION_OPEN;
            open_q   <= 8'h00;
        end else begin
            prev_sel <= bus.r_en ? region : REGION_OPEN;
            open_q   <= bus.r_data;
        end
    end

    always_comb begin
        case (prev_sel)
            REGION_RAM:    bus.r_data = ram_q;
            REGION_PPU:    bus.r_data = reg_data_rd;
            REGION_JOYPAD: bus.r_data = {7'b0, joy_q};
            default:       bus.r_data = open_q;
        endcase
    end

    a_reg_en_window : assert property (
        @(posedge clock) disable iff (!reset_n)
        reg_en == (bus.addr >= PPU_BASE && bus.addr < IO_BASE)
    );

endmodule : bus_decoder

`default_nettype wire

// ==== rtl/joypad_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module joypad_port (
    input  wire                            clock,
    input  wire                            reset_n,
    input  wire [io_pkg::BUTTON_COUNT-1:0] buttons,
    input  wire                            joy_write,
    input  wire                            joy_strobe_bit,
    input  wire                            joy_read,
    output logic                           joy_bit
);

    import io_pkg::*;

    joy_state_t              state;
    logic [BUTTON_COUNT-1:0] shift_q;
    logic [3:0]              read_cnt;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state    <= JOY_IDLE;
            shift_q  <= '0;
            read_cnt <= 4'd0;
        end else begin
            case (state)
                JOY_IDLE: begin
                    if (joy_write && joy_strobe_bit) begin
                        state <= JOY_STROBE;
                    end
                end
                JOY_STROBE: begin
                    // falling strobe captures the buttons
                    if (joy_write && !joy_strobe_bit) begin
                        shift_q  <= buttons;
                        read_cnt <= 4'd0;
                        state    <= JOY_SHIFT;
                    end
                end
                JOY_SHIFT: begin
                    if (joy_write && joy_strobe_bit) begin
                        state <= JOY_STROBE;
                    end else if (joy_read) begin
                        // ones fill in behind, so read nine sees 1
                        shift_q  <= {1'b1, shift_q[BUTTON_COUNT-1:1]};
                        read_cnt <= read_cnt + 4'd1;
                        if (read_cnt == 4'(BUTTON_COUNT)) begin
                            state <= JOY_IDLE;
                        end
                    end
                end
                default: begin
                    state <= JOY_IDLE;
                end
            endcase
        end
    end

    assign joy_bit = (state == JOY_SHIFT) ? shift_q[0] : 1'b0;

    a_state_legal : assert property (
        @(posedge clock) disable iff (!reset_n)
        state inside {JOY_IDLE, JOY_STROBE, JOY_SHIFT}
    );

endmodule : joypad_port

`default_nettype wire

// ==== rtl/nes_cpu_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module nes_cpu_bus #(
    parameter int RAM_WORDS = cpu_map_pkg::RAM_WORDS,
    parameter int DMA_BYTES = 256
) (
    input  wire              clock,
    input  wire              reset_n,
    input  wire  [15:0]      addr,
    input  wire              r_en,
    input  wire  [7:0]       w_data,
    output logic [7:0]       r_data,
    output logic             cpu_ready,
    output logic             reg_en,
    output io_pkg::ppu_reg_t reg_sel,
    output logic             reg_rw,
    output logic [7:0]       reg_data_wr,
    input  wire  [7:0]       reg_data_rd,
    input  wire  [7:0]       buttons
);

    cpu_bus_if host_bus ();
    cpu_bus_if dma_bus ();
    cpu_bus_if mem_bus ();

    logic       dma_start;
    logic [7:0] dma_page;
    logic       dma_busy;
    logic       joy_write;
    logic       joy_strobe_bit;
    logic       joy_read;
    logic       joy_bit;

    // host pins onto the host side of the arbiter
    assign host_bus.addr   = addr;
    assign host_bus.r_en   = r_en;
    assign host_bus.w_data = w_data;
    assign r_data          = host_bus.r_data;

    bus_arbiter bus_arbiter_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .host      (host_bus),
        .dma       (dma_bus),
        .mem       (mem_bus),
        .busy      (dma_busy),
        .cpu_ready (cpu_ready)
    );

    oam_dma #(
        .DMA_BYTES (DMA_BYTES)
    ) oam_dma_inst (
        .clock     (clock),
        .reset_n   (reset_n),
        .dma_start (dma_start),
        .dma_page  (dma_page),
        .busy      (dma_busy),
        .bus       (dma_bus)
    );

    bus_decoder #(
        .RAM_WORDS (RAM_WORDS)
    ) bus_decoder_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .bus            (mem_bus),
        .reg_en         (reg_en),
        .reg_sel        (reg_sel),
        .reg_rw         (reg_rw),
        .reg_data_wr    (reg_data_wr),
        .reg_data_rd    (reg_data_rd),
        .dma_start      (dma_start),
        .dma_page       (dma_page),
        .joy_write      (joy_write),
        .joy_strobe_bit (joy_strobe_bit),
        .joy_read       (joy_read),
        .joy_bit        (joy_bit)
    );

    joypad_port joypad_port_inst (
        .clock          (clock),
        .reset_n        (reset_n),
        .buttons        (buttons),
        .joy_write      (joy_write),
        .joy_strobe_bit (joy_strobe_bit),
        .joy_read       (joy_read),
        .joy_bit        (joy_bit)
    );

endmodule : nes_cpu_bus

`default_nettype wire

// ==== testbench/tb_nes_cpu_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_nes_cpu_bus;

    import cpu_map_pkg::*;
    import io_pkg::*;

    localparam int N_ACCESS   = 4000;
    localparam int JOY_ROUNDS = 20;
    localparam int RAM_AW     = $clog2(RAM_WORDS);

    logic        clock = 1'b0;
    logic        reset_n;
    logic [15:0] addr;
    logic        r_en;
    logic [7:0]  w_data;
    logic [7:0]  reg_data_rd = 8'h00;
    logic [7:0]  buttons;
    logic [7:0]  r_data;
    logic        cpu_ready;
    logic        reg_en;
    ppu_reg_t    reg_sel;
    logic        reg_rw;
    logic [7:0]  reg_data_wr;

    logic [31:0] lcg_state = 32'h43842bd8;
    logic [7:0]  ram_model [RAM_WORDS];
    logic [7:0]  ppu_model [8];
    // r_data expected in the current cycle, and what it answers
    logic [7:0]  exp_rdata;
    string       exp_tag;
    joy_state_t  joy_st;
    logic [7:0]  joy_latch;
    logic [3:0]  joy_cnt;
    logic [7:0]  btn_val;
    int          dma_bytes;
    int          cycle_count = 0;
    int          cycle_limit = 0;

    always #5 clock = ~clock;

    nes_cpu_bus nes_cpu_bus_inst (
        .clock       (clock),
        .reset_n     (reset_n),
        .addr        (addr),
        .r_en        (r_en),
        .w_data      (w_data),
        .r_data      (r_data),
        .cpu_ready   (cpu_ready),
        .reg_en      (reg_en),
        .reg_sel     (reg_sel),
        .reg_rw      (reg_rw),
        .reg_data_wr (reg_data_wr),
        .reg_data_rd (reg_data_rd),
        .buttons     (buttons)
    );

    // PPU stand-in, answers one cycle after the access
    always @(posedge clock) begin
        if (!reset_n) begin
            for (int i = 0; i < 8; i++) begin
                ppu_model[i] <= 8'(8'h3C ^ (i * 29));
            end
            reg_data_rd <= 8'h00;
        end else begin
            reg_data_rd <= ppu_model[reg_sel];
            if (reg_en && reg_rw) begin
                ppu_model[reg_sel] <= reg_data_wr;
            end
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_limit);
            stop_with_fail();
        end
    end

    task automatic stop_with_fail();
        $display("** FAIL **");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("Fail %s: expected %02h, actual %02h", name, exp, act);
            stop_with_fail();
        end
    endtask

    task automatic check_reg(input string name, input ppu_reg_t exp, input ppu_reg_t act);
        if (act !== exp) begin
            $display("Fail %s: expected %s, actual %s", name, exp.name(), act.name());
            stop_with_fail();
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail %s: expected %b, actual %b", name, exp, act);
            stop_with_fail();
        end
    endtask

    function automatic logic [23:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:8];
    endfunction

    function automatic bus_region_t region_of(input logic [15:0] a);
        if (a <= 16'h1FFF) return REGION_RAM;
        if (a <= 16'h3FFF) return REGION_PPU;
        if (a == OAMDMA_ADDR) return REGION_OAMDMA;
        if (a == JOYPAD_ADDR) return REGION_JOYPAD;
        return REGION_OPEN;
    endfunction

    // work RAM repeats every RAM_WORDS bytes
    function automatic logic [RAM_AW-1:0] ram_index(input logic [15:0] a);
        return RAM_AW'(a % 16'(RAM_WORDS));
    endfunction

    function automatic logic [15:0] open_address(input logic [23:0] s);
        case (s[23:22])
            2'd0: return 16'h4000 + 16'(int'(s[15:0]) % 20);
            2'd1: return 16'h4015;
            2'd2: return 16'h4017;
            default: return 16'h4018 + 16'(int'(s[15:0]) % 49128);
        endcase
    endfunction

    // controller as seen from the bus, A first and a trailing 1
    task automatic joypad_step(input logic rd, input logic strobe, output logic rbit);
        rbit = 1'b0;
        if (!rd) begin
            if (strobe) begin
                joy_st = JOY_STROBE;
            end else if (joy_st == JOY_STROBE) begin
                joy_latch = btn_val;
                joy_cnt   = 4'd0;
                joy_st    = JOY_SHIFT;
            end
        end else if (joy_st == JOY_SHIFT) begin
            rbit    = (joy_cnt < 4'(BUTTON_COUNT)) ? joy_latch[joy_cnt[2:0]] : 1'b1;
            joy_cnt = joy_cnt + 4'd1;
            if (joy_cnt > 4'(BUTTON_COUNT)) begin
                joy_st = JOY_IDLE;
            end
        end
    endtask

    task automatic dma_window(input logic [7:0] page);
        int          c;
        logic [23:0] r;
        logic [7:0]  src_byte;
        for (c = 0; c < 2 * dma_bytes; c++) begin
            r = next_random();
            @(posedge clock);
            // host keeps driving junk, none of it may reach the bus
            addr   <= r[15:0];
            r_en   <= r[16];
            w_data <= r[23:16];
            @(negedge clock);
            src_byte = ram_model[ram_index({page, 8'h00} + 16'(c / 2))];
            check_flag("dma cpu_ready", 1'b0, cpu_ready);
            check_byte(exp_tag, exp_rdata, r_data);
            if (c % 2 == 0) begin
                check_flag("dma read reg_en", 1'b0, reg_en);
                exp_rdata = src_byte;
                exp_tag   = "dma source read";
            end else begin
                check_flag("dma write reg_en", 1'b1, reg_en);
                check_reg("dma write reg_sel", OAMDATA, reg_sel);
                check_flag("dma write reg_rw", 1'b1, reg_rw);
                check_byte("dma write data", src_byte, reg_data_wr);
            end
        end
    endtask

    task automatic bus_cycle(input logic [15:0] a, input logic rd, input logic [7:0] wd);
        bus_region_t region;
        logic        jbit;
        logic [23:0] r;
        r = next_random();
        @(posedge clock);
        addr    <= a;
        r_en    <= rd;
        w_data  <= wd;
        buttons <= r[7:0];
        btn_val  = r[7:0];
        @(negedge clock);
        region = region_of(a);
        check_flag("cpu_ready", 1'b1, cpu_ready);
        check_byte(exp_tag, exp_rdata, r_data);
        check_flag("ppu reg_en", region == REGION_PPU, reg_en);
        if (region == REGION_PPU) begin
            check_reg("ppu reg_sel", ppu_reg_t'(a[2:0]), reg_sel);
            check_flag("ppu reg_rw", !rd, reg_rw);
            if (!rd) begin
                check_byte("ppu reg_data_wr", wd, reg_data_wr);
            end
        end
        // anything but a mapped read leaves the old value on the bus
        exp_tag = "open bus";
        if (region == REGION_RAM && rd) begin
            exp_rdata = ram_model[ram_index(a)];
            exp_tag   = "ram read";
        end else if (region == REGION_RAM) begin
            ram_model[ram_index(a)] = wd;
        end else if (region == REGION_PPU && rd) begin
            exp_rdata = ppu_model[a[2:0]];
            exp_tag   = "ppu read";
        end else if (region == REGION_JOYPAD) begin
            joypad_step(rd, wd[0], jbit);
            if (rd) begin
                exp_rdata = {7'b0, jbit};
                exp_tag   = "joypad read";
            end
        end else if (region == REGION_OAMDMA && !rd) begin
            dma_window(wd);
        end
    endtask

    task automatic joypad_round();
        bus_cycle(JOYPAD_ADDR, 1'b0, 8'h01);
        bus_cycle(JOYPAD_ADDR, 1'b0, 8'h00);
        repeat (BUTTON_COUNT + 1) begin
            bus_cycle(JOYPAD_ADDR, 1'b1, 8'h00);
        end
    endtask

    task automatic random_access();
        logic [23:0] r;
        logic [23:0] s;
        int          pick;
        r    = next_random();
        s    = next_random();
        pick = int'(r) % 100;
        if (pick < 2) begin
            bus_cycle(OAMDMA_ADDR, 1'b0, {5'b0, s[2:0]});
        end else if (pick < 45) begin
            bus_cycle({3'b000, s[12:0]}, s[13], s[21:14]);
        end else if (pick < 70) begin
            bus_cycle({3'b001, s[12:0]}, s[13], s[21:14]);
        end else if (pick < 85) begin
            bus_cycle(JOYPAD_ADDR, s[13], s[21:14]);
        end else begin
            bus_cycle(open_address(s), r[16], r[15:8]);
        end
    endtask

    initial begin
        int          i;
        logic [23:0] r;
        reset_n   = 1'b0;
        addr      = 16'h4018;
        r_en      = 1'b1;
        w_data    = 8'h00;
        buttons   = 8'h00;
        exp_rdata = 8'h00;
        exp_tag   = "r_data after reset";
        joy_st    = JOY_IDLE;
        joy_latch = 8'h00;
        joy_cnt   = 4'd0;
        btn_val   = 8'h00;
        dma_bytes = nes_cpu_bus_inst.DMA_BYTES;
        // reset, RAM fill, joypad rounds, then every access could be a DMA
        cycle_limit = 16 + RAM_WORDS + JOY_ROUNDS * (BUTTON_COUNT + 3)
                      + N_ACCESS * (1 + 2 * dma_bytes) + 1000;

        repeat (16) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_flag("reset cpu_ready", 1'b1, cpu_ready);
        check_flag("reset reg_en", 1'b0, reg_en);
        check_byte("reset r_data", 8'h00, r_data);

        // fill work RAM through random mirrors
        for (i = 0; i < RAM_WORDS; i++) begin
            r = next_random();
            bus_cycle(16'(i + int'(r[1:0]) * RAM_WORDS), 1'b0, r[15:8]);
        end

        for (i = 0; i < N_ACCESS; i++) begin
            if (i % (N_ACCESS / JOY_ROUNDS) == 0) begin
                joypad_round();
            end
            random_access();
        end
        // collect the answer to the last access
        bus_cycle(16'h4018, 1'b1, 8'h00);

        $display("** PASS **");
        $finish;
    end

endmodule : tb_nes_cpu_bus

`default_nettype wire

// ==== compile.f ====
rtl/cpu_map_pkg.sv
rtl/io_pkg.sv
rtl/cpu_bus_if.sv
rtl/bus_arbiter.sv
rtl/oam_dma.sv
rtl/bus_decoder.sv
rtl/joypad_port.sv
rtl/nes_cpu_bus.sv
testbench/tb_nes_cpu_bus.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_nes_cpu_bus
RTL_TOP    := nes_cpu_bus
FILELIST   := compile.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the verdict comes from the pass line in the simulator output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
